// File: flist.f
+incdir+source
source/rv_isa_pkg.sv
source/rv_core_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_lsu.sv
source/rv_pc_unit.sv
source/rv_core.sv
tests/rv_core_properties.sv
tests/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := rv_core_tb
FLIST     := flist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/rv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_core_tb;

  logic clk;
  logic rst;
  rv_isa_pkg::insn_t      imem_data;
  rv_isa_pkg::word_t      dmem_rdata;
  rv_isa_pkg::word_t      imem_addr;
  rv_core_pkg::dmem_req_t dmem_req;
  rv_core_pkg::retire_t   retire;
  logic                   halt;

  rv_isa_pkg::word_t imem [256];
  rv_isa_pkg::word_t dmem [256];
  // architectural model state
  rv_isa_pkg::word_t m_mem [256];
  rv_isa_pkg::word_t m_regs [`RV_NUM_REGS];
  rv_isa_pkg::word_t m_pc;
  logic              m_halted;
  // data memory request the model expects for the current instruction
  rv_isa_pkg::byte_en_t m_be;
  rv_isa_pkg::word_t    m_addr;
  logic [7:0]        prog_len;
  logic              prog_ready;
  int                errors;
  int                ecall_count;
  logic              seen_first;
  integer            seed;

  rv_core rv_core_inst (
    .clk        (clk),
    .rst        (rst),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_req   (dmem_req),
    .retire     (retire),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // both memories read combinationally, writes land at the edge
  always_comb imem_data = imem[imem_addr[9:2]];
  always_comb dmem_rdata = dmem[dmem_req.addr[9:2]];

  always @(posedge clk) begin
    if (!rst) begin
      for (int k = 0; k < `RV_BYTE_LANES; k++) begin
        if (dmem_req.be[k]) begin
          dmem[dmem_req.addr[9:2]][8*k +: 8] <= dmem_req.wdata[8*k +: 8];
        end
      end
    end
  end

  function automatic rv_isa_pkg::insn_t enc_i(logic [11:0] imm, rv_isa_pkg::reg_idx_t rs1,
                                              rv_isa_pkg::funct3_t f3, rv_isa_pkg::reg_idx_t rd,
                                              rv_isa_pkg::opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_r(rv_isa_pkg::funct7_t f7, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, rv_isa_pkg::funct3_t f3,
                                              rv_isa_pkg::reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_s(logic [11:0] imm, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, rv_isa_pkg::funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_b(logic [12:0] imm, rv_isa_pkg::reg_idx_t rs2,
                                              rv_isa_pkg::reg_idx_t rs1, rv_isa_pkg::funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_j(logic [20:0] imm, rv_isa_pkg::reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_u(logic [19:0] imm, rv_isa_pkg::reg_idx_t rd,
                                              rv_isa_pkg::opcode_e op);
    return {imm, rd, op};
  endfunction

  task automatic emit(input rv_isa_pkg::insn_t insn);
    imem[prog_len] = insn;
    prog_len = prog_len + 8'd1;
  endtask

  task automatic build_program();
    logic [31:0] r;
    emit(enc_i(12'h100, 5'd0, 3'd0, 5'd20, rv_isa_pkg::OP_IMM));
    // random operands in x1..x4, fixed -1 and 1 in x6, x7
    for (int k = 1; k <= 4; k++) begin
      r = $random(seed);
      emit(enc_u(r[31:12], 5'(k), rv_isa_pkg::OP_LUI));
      emit(enc_i(r[11:0], 5'(k), 3'd0, 5'(k), rv_isa_pkg::OP_IMM));
    end
    emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd6, rv_isa_pkg::OP_IMM));
    emit(enc_i(12'h001, 5'd0, 3'd0, 5'd7, rv_isa_pkg::OP_IMM));
    emit(enc_i(12'h2a5, 5'd0, 3'd0, 5'd5, rv_isa_pkg::OP_IMM));
    for (int k = 0; k < 8; k++) begin
      r = $random(seed);
      emit(enc_r(7'h00, 5'd2, 5'd1, 3'(k), 5'd10));
      emit(enc_r(7'h00, 5'd7, 5'd6, 3'(k), 5'd11));
      emit(enc_r(7'h00, 5'd4, 5'd3, 3'(k), 5'd12));
      if (k == 5 || k == 1) begin
        emit(enc_i({7'h00, r[4:0]}, 5'd1, 3'(k), 5'd13, rv_isa_pkg::OP_IMM));
      end else begin
        emit(enc_i(r[11:0], 5'd1, 3'(k), 5'd13, rv_isa_pkg::OP_IMM));
      end
    end
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd14));
    emit(enc_r(7'h20, 5'd2, 5'd6, 3'd5, 5'd14));
    emit(enc_i({7'h20, 5'd7}, 5'd1, 3'd5, 5'd14, rv_isa_pkg::OP_IMM));
    emit(enc_u(20'h8badc, 5'd15, rv_isa_pkg::OP_LUI));
    emit(enc_u(20'h00123, 5'd15, rv_isa_pkg::OP_AUIPC));
    // every branch on equal, lower and higher operands, skipping one addi when taken
    for (int k = 0; k < 8; k++) begin
      if (k != 2 && k != 3) begin
        emit(enc_b(13'd8, 5'd5, 5'd5, 3'(k)));
        emit(enc_i(12'h001, 5'd16, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
        emit(enc_b(13'd8, 5'd7, 5'd6, 3'(k)));
        emit(enc_i(12'h002, 5'd16, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
        emit(enc_b(13'd8, 5'd6, 5'd7, 3'(k)));
        emit(enc_i(12'h004, 5'd16, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
      end
    end
    emit(enc_j(21'd8, 5'd17));
    emit(enc_i(12'h001, 5'd16, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
    emit(enc_u(20'h00000, 5'd18, rv_isa_pkg::OP_AUIPC));
    // odd offset 13 checks that jalr drops bit 0
    emit(enc_i(12'd13, 5'd18, 3'd0, 5'd19, rv_isa_pkg::OP_JALR));
    emit(enc_i(12'h001, 5'd16, 3'd0, 5'd16, rv_isa_pkg::OP_IMM));
    emit(enc_i(12'h005, 5'd1, 3'd0, 5'd0, rv_isa_pkg::OP_IMM));
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd21));
    emit(enc_s(12'd0, 5'd1, 5'd20, 3'd2));
    for (int k = 0; k < 4; k++) begin
      emit(enc_s(12'(4 + k), 5'(k + 1), 5'd20, 3'd0));
    end
    emit(enc_s(12'd8, 5'd3, 5'd20, 3'd1));
    emit(enc_s(12'd10, 5'd6, 5'd20, 3'd1));
    for (int k = 0; k < 12; k++) begin
      emit(enc_i(12'(k), 5'd20, 3'd0, 5'd22, rv_isa_pkg::OP_LOAD));
      emit(enc_i(12'(k), 5'd20, 3'd4, 5'd23, rv_isa_pkg::OP_LOAD));
      if (k % 2 == 0) begin
        emit(enc_i(12'(k), 5'd20, 3'd1, 5'd24, rv_isa_pkg::OP_LOAD));
        emit(enc_i(12'(k), 5'd20, 3'd5, 5'd25, rv_isa_pkg::OP_LOAD));
      end
    end
    emit(enc_i(12'd0, 5'd20, 3'd2, 5'd26, rv_isa_pkg::OP_LOAD));
    emit(32'h0000_000f);
    emit(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd27));
    emit(32'h0000_0073);
  endtask

  function automatic rv_isa_pkg::word_t ref_alu(rv_isa_pkg::funct3_t f3, logic alt,
                                                rv_isa_pkg::word_t a, rv_isa_pkg::word_t b);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? rv_isa_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic ref_taken(rv_isa_pkg::funct3_t f3, rv_isa_pkg::word_t a,
                                     rv_isa_pkg::word_t b);
    case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // steps the model by one instruction and returns what should retire
  function automatic rv_core_pkg::retire_t step_model();
    rv_core_pkg::retire_t exp;
    rv_isa_pkg::insn_t    insn;
    rv_isa_pkg::funct3_t  f3;
    rv_isa_pkg::word_t    a;
    rv_isa_pkg::word_t    b;
    rv_isa_pkg::word_t    imm_i;
    rv_isa_pkg::word_t    addr;
    rv_isa_pkg::word_t    w;
    rv_isa_pkg::word_t    res;
    rv_isa_pkg::word_t    npc;
    logic                 we;
    int                   nbytes;
    insn   = imem[m_pc[9:2]];
    f3     = insn[14:12];
    a      = m_regs[insn[19:15]];
    b      = m_regs[insn[24:20]];
    imm_i  = {{20{insn[31]}}, insn[31:20]};
    npc    = m_pc + 32'd4;
    res    = '0;
    we     = 1'b0;
    m_be   = '0;
    m_addr = '0;
    case (insn[6:0])
      rv_isa_pkg::OP_LUI: begin
        res = {insn[31:12], 12'h000};
        we  = 1'b1;
      end
      rv_isa_pkg::OP_AUIPC: begin
        res = m_pc + {insn[31:12], 12'h000};
        we  = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        res = ref_alu(f3, (f3 == 3'd5) && insn[30], a, imm_i);
        we  = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        res = ref_alu(f3, insn[30], a, b);
        we  = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        if (ref_taken(f3, a, b)) begin
          npc = m_pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        end
      end
      rv_isa_pkg::OP_JAL: begin
        res = m_pc + 32'd4;
        we  = 1'b1;
        npc = m_pc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      rv_isa_pkg::OP_JALR: begin
        res = m_pc + 32'd4;
        we  = 1'b1;
        npc = (a + imm_i) & ~32'd1;
      end
      rv_isa_pkg::OP_LOAD: begin
        addr = a + imm_i;
        w    = m_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        we   = 1'b1;
        case (f3)
          3'd0: res = {{24{w[7]}}, w[7:0]};
          3'd1: res = {{16{w[15]}}, w[15:0]};
          3'd4: res = {24'h0, w[7:0]};
          3'd5: res = {16'h0, w[15:0]};
          default: res = w;
        endcase
      end
      rv_isa_pkg::OP_STORE: begin
        addr   = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
        m_addr = {addr[31:2], 2'b00};
        nbytes = (f3 == 3'd0) ? 1 : (f3 == 3'd1) ? 2 : 4;
        for (int j = 0; j < nbytes; j++) begin
          m_mem[addr[9:2]][8*(int'(addr[1:0]) + j) +: 8] = b[8*j +: 8];
          m_be[int'(addr[1:0]) + j] = 1'b1;
        end
      end
      rv_isa_pkg::OP_SYSTEM: begin
        if (insn == 32'h0000_0073) begin
          m_halted = 1'b1;
        end
      end
      default: begin
      end
    endcase
    we = we && (insn[11:7] != 5'd0);
    if (we) begin
      m_regs[insn[11:7]] = res;
    end
    exp = '{valid: 1'b1, pc: m_pc, insn: insn, rd_we: we, rd: insn[11:7], rd_data: res,
            next_pc: npc};
    m_pc = npc;
    return exp;
  endfunction

  // compare at the falling edge where the DUT outputs are settled
  always @(negedge clk) begin
    rv_core_pkg::retire_t exp;
    if (rst && retire.valid !== 1'b0) begin
      $display("[ERROR] retire.valid got %h expected 0 during reset", retire.valid);
      errors++;
    end
    if (!rst && prog_ready) begin
      if (retire.valid) begin
        if (m_halted) begin
          $display("retire is valid after the core halted");
          errors++;
        end
        if (!seen_first && (retire.pc !== `RV_RESET_PC || halt !== 1'b0)) begin
          $display("[ERROR] first retire pc %h halt %h", retire.pc, halt);
          errors++;
        end
        seen_first = 1'b1;
        if (retire.rd_we && retire.rd == 5'd0) begin
          $display("[ERROR] retire.rd_we set for rd %h", retire.rd);
          errors++;
        end
        if (retire.insn == 32'h0000_0073) begin
          ecall_count++;
        end
        exp = step_model();
        if (imem_addr !== exp.pc) begin
          $display("[ERROR] imem_addr got %h expected %h", imem_addr, exp.pc);
          errors++;
        end
        if (retire.pc !== exp.pc) begin
          $display("[ERROR] retire.pc got %h expected %h", retire.pc, exp.pc);
          errors++;
        end
        if (retire.insn !== exp.insn) begin
          $display("[ERROR] retire.insn got %h expected %h", retire.insn, exp.insn);
          errors++;
        end
        if (retire.rd_we !== exp.rd_we) begin
          $display("[ERROR] retire.rd_we got %h expected %h at pc %h", retire.rd_we,
                   exp.rd_we, exp.pc);
          errors++;
        end
        if (exp.rd_we && (retire.rd !== exp.rd || retire.rd_data !== exp.rd_data)) begin
          $display("[ERROR] retire.rd_data got x%0d=%h expected x%0d=%h at pc %h",
                   retire.rd, retire.rd_data, exp.rd, exp.rd_data, exp.pc);
          errors++;
        end
        if (retire.next_pc !== exp.next_pc) begin
          $display("[ERROR] retire.next_pc got %h expected %h", retire.next_pc, exp.next_pc);
          errors++;
        end
        if (dmem_req.be !== m_be) begin
          $display("[ERROR] dmem_req.be got %h expected %h at pc %h", dmem_req.be, m_be,
                   exp.pc);
          errors++;
        end
        if (m_be != '0 && dmem_req.addr !== m_addr) begin
          $display("[ERROR] dmem_req.addr got %h expected %h at pc %h", dmem_req.addr,
                   m_addr, exp.pc);
          errors++;
        end
      end else if (!m_halted || halt !== 1'b1) begin
        $display("core stopped retiring without a completed ecall");
        errors++;
      end
    end
  end

  initial begin
    rv_isa_pkg::word_t fill;
    seed        = 32'h8ef0;
    rst         = 1'b1;
    errors      = 0;
    ecall_count = 0;
    seen_first  = 1'b0;
    prog_ready  = 1'b0;
    prog_len    = 8'd0;
    m_pc        = `RV_RESET_PC;
    m_halted    = 1'b0;
    for (int i = 0; i < 256; i++) begin
      fill       = 32'h5a3c_0000 ^ (32'(i) * 32'h0101_0107);
      dmem[i]    = fill;
      m_mem[i]   = fill;
      imem[i]    = enc_i(12'(i), 5'd0, 3'd0, 5'd0, rv_isa_pkg::OP_IMM);
    end
    for (int i = 0; i < `RV_NUM_REGS; i++) begin
      m_regs[i] = '0;
    end
    build_program();
    prog_ready = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    wait (m_halted);
    repeat (5) @(negedge clk);
    if (ecall_count != 1) begin
      $display("ecall retired %0d times instead of once", ecall_count);
      errors++;
    end
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // the program has no backward jumps, so its length bounds the run
  initial begin
    wait (prog_ready);
    repeat (8 + int'(prog_len) + 40) @(posedge clk);
    $display("timeout: the core did not halt within the expected number of cycles");
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/rv_core_properties.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_properties (
  input logic                   clk,
  input logic                   rst,
  input rv_isa_pkg::word_t      imem_addr,
  input rv_core_pkg::dmem_req_t dmem_req,
  input rv_core_pkg::retire_t   retire,
  input logic                   halt
);

  pc_aligned: assert property (@(posedge clk) disable iff (rst) imem_addr[1:0] == 2'b00)
    else $error("pc is not word aligned");

  dmem_aligned: assert property (@(posedge clk) disable iff (rst) dmem_req.addr[1:0] == 2'b00)
    else $error("data memory address is not word aligned");

  // a halted core holds its pc and never writes
  halt_pc_hold: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(imem_addr))
    else $error("pc moved while halted");

  halt_no_write: assert property (@(posedge clk) disable iff (rst) halt |-> dmem_req.be == '0)
    else $error("byte enables set while halted");

  no_x0_write: assert property (@(posedge clk) disable iff (rst) retire.rd_we |-> retire.rd != '0)
    else $error("retire reports a write to x0");

endmodule

bind rv_core rv_core_properties props_inst (
  .clk       (clk),
  .rst       (rst),
  .imem_addr (imem_addr),
  .dmem_req  (dmem_req),
  .retire    (retire),
  .halt      (halt)
);

`default_nettype wire

// File: source/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_isa_pkg::insn_t      imem_data,
  input  rv_isa_pkg::word_t      dmem_rdata,
  output rv_isa_pkg::word_t      imem_addr,
  output rv_core_pkg::dmem_req_t dmem_req,
  output rv_core_pkg::retire_t   retire,
  output logic                   halt
);

  rv_core_pkg::ctrl_t ctrl;
  rv_isa_pkg::word_t  rs1_data;
  rv_isa_pkg::word_t  rs2_data;
  rv_isa_pkg::word_t  alu_result;
  logic               taken;
  rv_isa_pkg::word_t  load_value;
  rv_isa_pkg::word_t  pc;
  rv_isa_pkg::word_t  next_pc;
  logic               running;
  rv_isa_pkg::word_t  wb_data;

  rv_decoder decoder_inst (
    .insn (imem_data),
    .ctrl (ctrl)
  );

  // links write pc + 4, loads write the extended value
  assign wb_data = ctrl.load ? load_value :
                   (ctrl.jal || ctrl.jalr) ? pc + 32'd4 : alu_result;

  rv_regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .we       (ctrl.reg_write && running),
    .rd       (ctrl.rd),
    .rd_data  (wb_data),
    .rs1      (ctrl.rs1),
    .rs2      (ctrl.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu alu_inst (
    .op     (ctrl.alu_op),
    .a      (ctrl.op_a_pc ? pc : rs1_data),
    .b      (ctrl.op_b_imm ? ctrl.imm : rs2_data),
    .result (alu_result),
    .taken  (taken)
  );

  // load and store addresses come out of the alu add
  rv_lsu lsu_inst (
    .ctrl       (ctrl),
    .addr       (alu_result),
    .store_data (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_value (load_value)
  );

  rv_pc_unit pc_unit_inst (
    .clk           (clk),
    .rst           (rst),
    .ctrl          (ctrl),
    .taken         (taken),
    .pc_rel_target (pc + ctrl.imm),
    .jalr_target   (alu_result),
    .pc            (pc),
    .next_pc       (next_pc),
    .running       (running)
  );

  assign imem_addr = pc;
  assign halt      = !running;

  assign retire = '{
    valid:   running,
    pc:      pc,
    insn:    imem_data,
    rd_we:   ctrl.reg_write && running,
    rd:      ctrl.rd,
    rd_data: wb_data,
    next_pc: next_pc
  };

endmodule

`default_nettype wire

// File: source/rv_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_pc_unit (
  input  logic               clk,
  input  logic               rst,
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic               taken,
  input  rv_isa_pkg::word_t  pc_rel_target,
  input  rv_isa_pkg::word_t  jalr_target,
  output rv_isa_pkg::word_t  pc,
  output rv_isa_pkg::word_t  next_pc,
  output logic               running
);

  typedef enum logic {
    ST_RUN,
    ST_HALTED
  } state_e;

  state_e state;

  always_comb begin
    if (ctrl.jalr) begin
      next_pc = {jalr_target[`RV_XLEN-1:1], 1'b0};
    end else if (ctrl.jal || (ctrl.branch && taken)) begin
      next_pc = pc_rel_target;
    end else begin
      next_pc = pc + 32'd4;
    end
  end

  // ecall parks the pc on itself, so the held fetch is the ecall again
  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= `RV_RESET_PC;
      state <= ST_RUN;
    end else if (state == ST_RUN) begin
      if (ctrl.halt) begin
        state <= ST_HALTED;
      end else begin
        pc <= next_pc;
      end
    end
  end

  // nothing retires while the core is held in reset
  assign running = (state == ST_RUN) && !rst;

endmodule

`default_nettype wire

// File: source/rv_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_lsu (
  input  rv_core_pkg::ctrl_t     ctrl,
  input  rv_isa_pkg::word_t      addr,
  input  rv_isa_pkg::word_t      store_data,
  input  rv_isa_pkg::word_t      dmem_rdata,
  output rv_core_pkg::dmem_req_t dmem_req,
  output rv_isa_pkg::word_t      load_value
);

  logic [1:0]        offset;
  logic [4:0]        lane_shift;
  rv_isa_pkg::word_t lane_data;

  assign offset     = addr[1:0];
  assign lane_shift = {offset, 3'b000};

  // store side, data moves up into the addressed lane
  always_comb begin
    dmem_req.addr  = {addr[`RV_XLEN-1:2], 2'b00};
    dmem_req.wdata = store_data << lane_shift;
    dmem_req.be    = '0;
    if (ctrl.store) begin
      case (rv_isa_pkg::mem_f3_e'(ctrl.mem_size))
        rv_isa_pkg::F3_MEM_B: dmem_req.be = rv_isa_pkg::byte_en_t'(1) << offset;
        rv_isa_pkg::F3_MEM_H: dmem_req.be = rv_isa_pkg::byte_en_t'(3) << offset;
        default:              dmem_req.be = {`RV_BYTE_LANES{1'b1}};
      endcase
    end
  end

  // load side, addressed lane moves down to bit 0 before extension
  assign lane_data = dmem_rdata >> lane_shift;

  always_comb begin
    case (rv_isa_pkg::mem_f3_e'(ctrl.mem_size))
      rv_isa_pkg::F3_MEM_B:  load_value = {{(`RV_XLEN-8){lane_data[7]}}, lane_data[7:0]};
      rv_isa_pkg::F3_MEM_H:  load_value = {{(`RV_XLEN-16){lane_data[15]}}, lane_data[15:0]};
      rv_isa_pkg::F3_MEM_BU: load_value = {{(`RV_XLEN-8){1'b0}}, lane_data[7:0]};
      rv_isa_pkg::F3_MEM_HU: load_value = {{(`RV_XLEN-16){1'b0}}, lane_data[15:0]};
      default:               load_value = lane_data;
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_alu (
  input  rv_core_pkg::alu_op_e op,
  input  rv_isa_pkg::word_t    a,
  input  rv_isa_pkg::word_t    b,
  output rv_isa_pkg::word_t    result,
  output logic                 taken
);

  localparam int ShamtW = $clog2(`RV_XLEN);

  logic [ShamtW-1:0] shamt;
  logic              eq;
  logic              lt_s;
  logic              lt_u;

  assign shamt = b[ShamtW-1:0];
  assign eq    = (a == b);
  assign lt_s  = ($signed(a) < $signed(b));
  assign lt_u  = (a < b);

  // branch compares, also used by slt and sltu
  always_comb begin
    case (op)
      rv_core_pkg::ALU_EQ:  taken = eq;
      rv_core_pkg::ALU_NE:  taken = !eq;
      rv_core_pkg::ALU_LT:  taken = lt_s;
      rv_core_pkg::ALU_GE:  taken = !lt_s;
      rv_core_pkg::ALU_LTU: taken = lt_u;
      rv_core_pkg::ALU_GEU: taken = !lt_u;
      default:              taken = 1'b0;
    endcase
  end

  always_comb begin
    case (op)
      rv_core_pkg::ALU_SUB:  result = a - b;
      rv_core_pkg::ALU_SLL:  result = a << shamt;
      rv_core_pkg::ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_s};
      rv_core_pkg::ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_u};
      rv_core_pkg::ALU_XOR:  result = a ^ b;
      rv_core_pkg::ALU_SRL:  result = a >> shamt;
      rv_core_pkg::ALU_SRA:  result = rv_isa_pkg::word_t'($signed(a) >>> shamt);
      rv_core_pkg::ALU_OR:   result = a | b;
      rv_core_pkg::ALU_AND:  result = a & b;
      rv_core_pkg::ALU_ADD:  result = a + b;
      // compare ops return the flag zero extended
      default:               result = {{(`RV_XLEN-1){1'b0}}, taken};
    endcase
  end

endmodule

`default_nettype wire

// File: source/rv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_macros.svh"

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  rv_isa_pkg::reg_idx_t rd,
  input  rv_isa_pkg::word_t    rd_data,
  input  rv_isa_pkg::reg_idx_t rs1,
  input  rv_isa_pkg::reg_idx_t rs2,
  output rv_isa_pkg::word_t    rs1_data,
  output rv_isa_pkg::word_t    rs2_data
);

  rv_isa_pkg::word_t regs [`RV_NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
    end else if (we) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 reads as zero whatever its storage holds
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// File: source/rv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
  input  rv_isa_pkg::insn_t  insn,
  output rv_core_pkg::ctrl_t ctrl
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::funct7_t funct7;
  rv_isa_pkg::word_t   imm_i;
  rv_isa_pkg::word_t   imm_s;
  rv_isa_pkg::word_t   imm_b;
  rv_isa_pkg::word_t   imm_j;
  rv_isa_pkg::word_t   imm_u;

  // alt selects sub and sra, only reg-reg has a sub
  function automatic rv_core_pkg::alu_op_e arith_op(rv_isa_pkg::funct3_t f3, logic alt,
                                                    logic is_reg);
    case (rv_isa_pkg::alu_f3_e'(f3))
      rv_isa_pkg::F3_ADD:  return (alt && is_reg) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return rv_core_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return rv_core_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return rv_core_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return rv_core_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return rv_core_pkg::ALU_OR;
      default:             return rv_core_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rv_core_pkg::alu_op_e branch_op(rv_isa_pkg::funct3_t f3);
    case (rv_isa_pkg::branch_f3_e'(f3))
      rv_isa_pkg::F3_BNE:  return rv_core_pkg::ALU_NE;
      rv_isa_pkg::F3_BLT:  return rv_core_pkg::ALU_LT;
      rv_isa_pkg::F3_BGE:  return rv_core_pkg::ALU_GE;
      rv_isa_pkg::F3_BLTU: return rv_core_pkg::ALU_LTU;
      rv_isa_pkg::F3_BGEU: return rv_core_pkg::ALU_GEU;
      default:             return rv_core_pkg::ALU_EQ;
    endcase
  endfunction

  assign opcode = rv_isa_pkg::opcode_e'(insn[6:0]);
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  // immediates, all sign extended from insn[31] except U
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    ctrl          = '0;
    ctrl.alu_op   = rv_core_pkg::ALU_ADD;
    ctrl.mem_size = funct3;
    ctrl.rd       = insn[11:7];
    ctrl.rs1      = insn[19:15];
    ctrl.rs2      = insn[24:20];

    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        // x0 as operand a turns the add into a plain pass of imm
        ctrl.rs1       = '0;
        ctrl.op_b_imm  = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_AUIPC: begin
        ctrl.op_a_pc   = 1'b1;
        ctrl.op_b_imm  = 1'b1;
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        ctrl.alu_op    = arith_op(funct3, funct7[5], 1'b0);
        ctrl.op_b_imm  = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_REG: begin
        ctrl.alu_op    = arith_op(funct3, funct7[5], 1'b1);
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_BRANCH: begin
        ctrl.alu_op = branch_op(funct3);
        ctrl.imm    = imm_b;
        ctrl.branch = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        ctrl.imm       = imm_j;
        ctrl.jal       = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_JALR: begin
        ctrl.op_b_imm  = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.jalr      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_LOAD: begin
        ctrl.op_b_imm  = 1'b1;
        ctrl.imm       = imm_i;
        ctrl.load      = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      rv_isa_pkg::OP_STORE: begin
        ctrl.op_b_imm = 1'b1;
        ctrl.imm      = imm_s;
        ctrl.store    = 1'b1;
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // only ecall is recognized, every other system op is a no-op
        if (insn[31:7] == '0) begin
          ctrl.halt = 1'b1;
        end
      end
      // fence and unknown opcodes fall through as no-ops
      default: begin
      end
    endcase

    // x0 is never written
    if (ctrl.rd == '0) begin
      ctrl.reg_write = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

  // arithmetic ops first, then the branch compares
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  typedef struct packed {
    alu_op_e              alu_op;
    logic                 op_b_imm;
    logic                 op_a_pc;
    logic                 reg_write;
    logic                 load;
    logic                 store;
    logic                 branch;
    logic                 jal;
    logic                 jalr;
    logic                 halt;
    rv_isa_pkg::funct3_t  mem_size;
    rv_isa_pkg::word_t    imm;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
  } ctrl_t;

  // addr is always word aligned
  typedef struct packed {
    rv_isa_pkg::word_t    addr;
    rv_isa_pkg::word_t    wdata;
    rv_isa_pkg::byte_en_t be;
  } dmem_req_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::insn_t    insn;
    logic                 rd_we;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    rd_data;
    rv_isa_pkg::word_t    next_pc;
  } retire_t;

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

`include "rv_macros.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_XLEN-1:0] insn_t;
  typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;
  typedef logic [`RV_BYTE_LANES-1:0] byte_en_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_STORE    = 7'b01_000_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_JAL      = 7'b11_011_11,
    OP_IMM      = 7'b00_100_11,
    OP_REG      = 7'b01_100_11,
    OP_SYSTEM   = 7'b11_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_LUI      = 7'b01_101_11
  } opcode_e;

  // funct3 of the integer ops, shared by reg-imm and reg-reg
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_f3_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_e;

  // access size of loads and stores, stores use only B, H and W
  typedef enum logic [2:0] {
    F3_MEM_B  = 3'b000,
    F3_MEM_H  = 3'b001,
    F3_MEM_W  = 3'b010,
    F3_MEM_BU = 3'b100,
    F3_MEM_HU = 3'b101
  } mem_f3_e;

endpackage

`default_nettype wire

// File: source/rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// RV32I data path width
`define RV_XLEN 32

// architectural register file
`define RV_NUM_REGS 32
`define RV_REG_IDX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// one write enable per byte of a word
`define RV_BYTE_LANES 4

`endif
